/* dma_lite.f */
hdl/dma_pkg.sv
hdl/dma_config_slave.sv
hdl/dma_request_table.sv
hdl/dma_transfer_fsm.sv
hdl/dma_word_counter.sv
hdl/dma_remote_port.sv
hdl/dma_bus_arbiter.sv
hdl/dma_top.sv
sim/tb_dma_mem.sv
sim/tb_dma_top.sv

/* Makefile */
# Verilator build and run of the DMA controller testbench

VERILATOR ?= verilator
TOP       ?= tb_dma_top
FILELIST  ?= dma_lite.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) 2>&1 | tee $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@grep -qF '*** TEST PASSED ***' $(LOG) || { echo "No pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/tb_dma_top.sv */
/*
 * DMA controller testbench
 * Runs a table of configuration, remote access, interrupt and
 * memory image steps against the DUT and a wait-state memory
 */

`timescale 1ns/1ps
`default_nettype none

module tb_dma_top
  import dma_pkg::*;
();

  localparam int    TABLE_ENTRIES = 4;
  localparam int    MEM_WORDS     = 1024;
  localparam data_t FILL_BASE     = 32'h5A00_0000;
  localparam int    MAX_LEN       = 8;  // Longest copy in the table
  localparam int    WORD_CYCLES   = 12; // Lock, arbitration, read and write at 3 waits
  localparam int    STEP_CYCLES   = TABLE_ENTRIES * MAX_LEN * WORD_CYCLES + 40;

  typedef enum logic [2:0] {
    OP_CFG_WR,
    OP_CFG_RD,
    OP_REM_WR,
    OP_REM_RD,
    OP_REM_HOLD,
    OP_WAIT_IRQ,
    OP_CHK_IRQ,
    OP_MEM_CHK
  } step_op_e;

  typedef struct packed {
    step_op_e    op;
    addr_t       addr;
    data_t       data; // Write data or expected value
    logic [31:0] arg;  // Hold cycles or irq mask
  } step_t;

  logic clk = 1'b0;
  logic rst;

  logic  cfg_sel;
  addr_t cfg_addr;
  logic  cfg_write;
  data_t cfg_wdata;
  data_t cfg_rdata;
  logic  cfg_ready;

  logic  bus_sel;
  addr_t bus_addr;
  logic  bus_write;
  data_t bus_wdata;
  data_t bus_rdata;
  logic  bus_ready;
  logic  bus_lock;

  logic  rem_req_valid;
  logic  rem_req_ready;
  logic  rem_req_write;
  addr_t rem_req_addr;
  data_t rem_req_wdata;
  logic  rem_res_valid;
  logic  rem_res_ready;
  data_t rem_res_rdata;

  logic [TABLE_ENTRIES-1:0] irq;

  step_t steps [$];
  data_t exp_mem [MEM_WORDS]; // Expected memory image
  addr_t sh_src [TABLE_ENTRIES];
  addr_t sh_dst [TABLE_ENTRIES];
  len_t  sh_len [TABLE_ENTRIES];
  int    cycle_count = 0;
  int    cycle_limit = 0;
  int    err_count   = 0;

  always #5 clk = ~clk;

  dma_top #(.TABLE_ENTRIES(TABLE_ENTRIES)) i_dut (
    .clk           (clk),
    .rst           (rst),
    .cfg_sel       (cfg_sel),
    .cfg_addr      (cfg_addr),
    .cfg_write     (cfg_write),
    .cfg_wdata     (cfg_wdata),
    .cfg_rdata     (cfg_rdata),
    .cfg_ready     (cfg_ready),
    .bus_sel       (bus_sel),
    .bus_addr      (bus_addr),
    .bus_write     (bus_write),
    .bus_wdata     (bus_wdata),
    .bus_rdata     (bus_rdata),
    .bus_ready     (bus_ready),
    .bus_lock      (bus_lock),
    .rem_req_valid (rem_req_valid),
    .rem_req_ready (rem_req_ready),
    .rem_req_write (rem_req_write),
    .rem_req_addr  (rem_req_addr),
    .rem_req_wdata (rem_req_wdata),
    .rem_res_valid (rem_res_valid),
    .rem_res_ready (rem_res_ready),
    .rem_res_rdata (rem_res_rdata),
    .irq           (irq)
  );

  tb_dma_mem #(.DEPTH(MEM_WORDS), .FILL_BASE(FILL_BASE), .SEED(37444)) i_mem (
    .clk       (clk),
    .rst       (rst),
    .bus_sel   (bus_sel),
    .bus_addr  (bus_addr),
    .bus_write (bus_write),
    .bus_wdata (bus_wdata),
    .bus_rdata (bus_rdata),
    .bus_ready (bus_ready)
  );

  //////////////////////////////////////////////////////////////////////
  // Failure handling and run limit

  task automatic fail_stop();
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped after an error");
  endtask

  task automatic check_value(input string what, input data_t got, input data_t exp);
    assert (got === exp) else begin
      $display("[FAIL] %0t %s is %h, expected %h", $time, what, got, exp);
      err_count++;
      fail_stop();
    end
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Timeout, the run did not finish within %0d clock cycles", cycle_limit);
      fail_stop();
    end
  end

  // Every master bus transfer runs under the owner's lock
  always @(posedge clk) begin
    if (!rst && bus_sel) begin
      assert (bus_lock) else begin
        $display("[FAIL] %0t bus_sel at %h without bus_lock", $time, bus_addr);
        fail_stop();
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Bus access tasks

  task automatic cfg_access(input logic wr, input addr_t a, input data_t wd,
                            output data_t rd);
    @(posedge clk);
    cfg_sel   <= 1'b1;
    cfg_write <= wr;
    cfg_addr  <= a;
    cfg_wdata <= wd;
    @(posedge clk);
    while (!cfg_ready) @(posedge clk);
    rd = cfg_rdata;
    cfg_sel   <= 1'b0;
    cfg_write <= 1'b0;
  endtask

  // A nonzero hold keeps rem_res_ready low for that many cycles
  task automatic remote_access(input logic wr, input addr_t a, input data_t wd,
                               input int hold, output data_t rd);
    @(posedge clk);
    rem_req_valid <= 1'b1;
    rem_req_write <= wr;
    rem_req_addr  <= a;
    rem_req_wdata <= wd;
    rem_res_ready <= (hold == 0);
    @(posedge clk);
    while (!rem_req_ready) @(posedge clk);
    rem_req_valid <= 1'b0;
    while (!rem_res_valid) @(posedge clk);
    rd = rem_res_rdata;
    for (int c = 0; c < hold; c++) begin
      @(posedge clk);
      assert (rem_res_valid && !rem_req_ready) else begin
        $display("[FAIL] %0t response dropped or new request allowed under back-pressure",
                 $time);
        err_count++;
        fail_stop();
      end
      check_value("held response data", rem_res_rdata, rd);
    end
    if (hold > 0) begin
      rem_res_ready <= 1'b1;
      @(posedge clk); // Response taken here
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model of the descriptors and memory

  function automatic addr_t reg_addr(input int e, input reg_sel_e r);
    return (addr_t'(e) << ENTRY_SHIFT) | (addr_t'(r) << 2);
  endfunction

  function automatic void record_cfg(input addr_t a, input data_t d);
    int e;
    e = int'(a >> ENTRY_SHIFT);
    case (reg_sel_e'(a[3:2]))
      REG_SRC: sh_src[e] = d;
      REG_DST: sh_dst[e] = d;
      REG_LEN: sh_len[e] = d[15:0];
      default: ;
    endcase
  endfunction

  function automatic void apply_copy(input int e);
    int s;
    int d;
    s = int'(sh_src[e] >> 2);
    d = int'(sh_dst[e] >> 2);
    for (int k = 0; k < int'(sh_len[e]); k++) begin
      exp_mem[d + k] = exp_mem[s + k];
    end
  endfunction

  task automatic wait_irq(input logic [TABLE_ENTRIES-1:0] mask);
    @(posedge clk);
    while ((irq & mask) != mask) @(posedge clk);
    for (int e = 0; e < TABLE_ENTRIES; e++) begin
      if (mask[e]) apply_copy(e);
    end
  endtask

  task automatic compare_memory();
    for (int i = 0; i < MEM_WORDS; i++) begin
      assert (i_mem.mem[i] === exp_mem[i]) else begin
        $display("[FAIL] %0t memory word at %h is %h, expected %h",
                 $time, i * 4, i_mem.mem[i], exp_mem[i]);
        err_count++;
        fail_stop();
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus table

  function automatic void add_step(input step_op_e op, input addr_t a, input data_t d,
                                   input logic [31:0] arg);
    step_t s;
    s.op   = op;
    s.addr = a;
    s.data = d;
    s.arg  = arg;
    steps.push_back(s);
  endfunction

  function automatic void build_table();
    // Register read back, CTRL clear before any start
    add_step(OP_CFG_WR, reg_addr(0, REG_SRC), 32'h100, 0);
    add_step(OP_CFG_WR, reg_addr(0, REG_DST), 32'h800, 0);
    add_step(OP_CFG_WR, reg_addr(0, REG_LEN), 32'd8, 0);
    add_step(OP_CFG_WR, reg_addr(2, REG_SRC), 32'h300, 0);
    add_step(OP_CFG_WR, reg_addr(2, REG_DST), 32'hA00, 0);
    add_step(OP_CFG_WR, reg_addr(2, REG_LEN), 32'd6, 0);
    add_step(OP_CFG_RD, reg_addr(0, REG_SRC), 32'h100, 0);
    add_step(OP_CFG_RD, reg_addr(0, REG_DST), 32'h800, 0);
    add_step(OP_CFG_RD, reg_addr(0, REG_LEN), 32'd8, 0);
    add_step(OP_CFG_RD, reg_addr(2, REG_SRC), 32'h300, 0);
    add_step(OP_CFG_RD, reg_addr(2, REG_DST), 32'hA00, 0);
    add_step(OP_CFG_RD, reg_addr(2, REG_LEN), 32'd6, 0);
    for (int e = 0; e < TABLE_ENTRIES; e++) begin
      add_step(OP_CFG_RD, reg_addr(e, REG_CTRL), 32'd0, 0);
    end
    // Single copy, then done, irq and restart
    add_step(OP_CFG_WR, reg_addr(0, REG_CTRL), 32'd1, 0);
    add_step(OP_WAIT_IRQ, '0, '0, 32'b0001);
    add_step(OP_MEM_CHK, '0, '0, 0);
    add_step(OP_CFG_RD, reg_addr(0, REG_CTRL), 32'd2, 0);
    add_step(OP_CHK_IRQ, '0, 32'b0001, 0);
    add_step(OP_CFG_WR, reg_addr(0, REG_CTRL), 32'd1, 0);
    add_step(OP_CFG_RD, reg_addr(0, REG_CTRL), 32'd1, 0);
    add_step(OP_CHK_IRQ, '0, 32'b0000, 0);
    add_step(OP_WAIT_IRQ, '0, '0, 32'b0001);
    add_step(OP_CFG_RD, reg_addr(0, REG_CTRL), 32'd2, 0);
    add_step(OP_MEM_CHK, '0, '0, 0);
    // Remote port alone
    add_step(OP_REM_WR, 32'hC00, 32'hDEAD_BEEF, 0);
    add_step(OP_REM_RD, 32'hC00, '0, 0);
    add_step(OP_REM_HOLD, 32'h040, '0, 4);
    add_step(OP_REM_WR, 32'hC00, 32'h0123_4567, 0);
    add_step(OP_REM_RD, 32'hC00, '0, 0);
    add_step(OP_MEM_CHK, '0, '0, 0);
    // Two copies with remote traffic in between
    add_step(OP_CFG_WR, reg_addr(1, REG_SRC), 32'h200, 0);
    add_step(OP_CFG_WR, reg_addr(1, REG_DST), 32'h900, 0);
    add_step(OP_CFG_WR, reg_addr(1, REG_LEN), 32'd5, 0);
    add_step(OP_CFG_WR, reg_addr(1, REG_CTRL), 32'd1, 0);
    add_step(OP_CFG_WR, reg_addr(2, REG_CTRL), 32'd1, 0);
    add_step(OP_REM_WR, 32'hC04, 32'hA5A5_0001, 0);
    add_step(OP_REM_RD, 32'h104, '0, 0);
    add_step(OP_REM_WR, 32'hC08, 32'h5A5A_0002, 0);
    add_step(OP_REM_RD, 32'hC04, '0, 0);
    add_step(OP_REM_HOLD, 32'hC08, '0, 3);
    add_step(OP_REM_RD, 32'h30C, '0, 0);
    add_step(OP_WAIT_IRQ, '0, '0, 32'b0110);
    add_step(OP_CHK_IRQ, '0, 32'b0111, 0);
    add_step(OP_CFG_RD, reg_addr(1, REG_CTRL), 32'd2, 0);
    add_step(OP_CFG_RD, reg_addr(2, REG_CTRL), 32'd2, 0);
    add_step(OP_MEM_CHK, '0, '0, 0);
    // Zero length entry finishes at once
    add_step(OP_CFG_WR, reg_addr(3, REG_SRC), 32'h400, 0);
    add_step(OP_CFG_WR, reg_addr(3, REG_DST), 32'hB00, 0);
    add_step(OP_CFG_WR, reg_addr(3, REG_LEN), 32'd0, 0);
    add_step(OP_CFG_WR, reg_addr(3, REG_CTRL), 32'd1, 0);
    add_step(OP_WAIT_IRQ, '0, '0, 32'b1000);
    add_step(OP_CHK_IRQ, '0, 32'b1111, 0);
    add_step(OP_MEM_CHK, '0, '0, 0);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    step_t st;
    data_t rd;
    rst           = 1'b1;
    cfg_sel       = 1'b0;
    cfg_addr      = '0;
    cfg_write     = 1'b0;
    cfg_wdata     = '0;
    rem_req_valid = 1'b0;
    rem_req_write = 1'b0;
    rem_req_addr  = '0;
    rem_req_wdata = '0;
    rem_res_ready = 1'b1;
    for (int i = 0; i < MEM_WORDS; i++) begin
      exp_mem[i] = addr_t'(i * 4) + FILL_BASE; // Same preload rule as the memory
    end
    for (int e = 0; e < TABLE_ENTRIES; e++) begin
      sh_src[e] = '0;
      sh_dst[e] = '0;
      sh_len[e] = '0;
    end
    build_table();
    cycle_limit = (steps.size() + 1) * STEP_CYCLES;

    repeat (5) @(posedge clk);
    rst <= 1'b0;

    foreach (steps[i]) begin
      st = steps[i];
      case (st.op)
        OP_CFG_WR: begin
          cfg_access(1'b1, st.addr, st.data, rd);
          record_cfg(st.addr, st.data);
        end
        OP_CFG_RD: begin
          cfg_access(1'b0, st.addr, '0, rd);
          check_value($sformatf("config read at %h", st.addr), rd, st.data);
        end
        OP_REM_WR: begin
          remote_access(1'b1, st.addr, st.data, 0, rd);
          exp_mem[st.addr[11:2]] = st.data;
        end
        OP_REM_RD: begin
          remote_access(1'b0, st.addr, '0, 0, rd);
          check_value($sformatf("remote read at %h", st.addr), rd, exp_mem[st.addr[11:2]]);
        end
        OP_REM_HOLD: begin
          remote_access(1'b0, st.addr, '0, int'(st.arg), rd);
          check_value($sformatf("held read at %h", st.addr), rd, exp_mem[st.addr[11:2]]);
        end
        OP_WAIT_IRQ: wait_irq(st.arg[TABLE_ENTRIES-1:0]);
        OP_CHK_IRQ: begin
          @(posedge clk);
          check_value("irq lines", data_t'(irq), st.data);
        end
        default: compare_memory();
      endcase
    end

    repeat (2) @(posedge clk);
    if (err_count == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      fail_stop();
    end
  end

endmodule

`default_nettype wire

/* sim/tb_dma_mem.sv */
/*
 * Master bus slave memory model
 * Word memory preloaded with address plus a base value,
 * answers each access after 0 to 3 random wait states
 */

`timescale 1ns/1ps
`default_nettype none

module tb_dma_mem
  import dma_pkg::*;
#(
  parameter int    DEPTH     = 1024,
  parameter data_t FILL_BASE = 32'h5A00_0000,
  parameter int    SEED      = 37444
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  bus_sel,
  input  addr_t bus_addr,
  input  logic  bus_write,
  input  data_t bus_wdata,
  output data_t bus_rdata,
  output logic  bus_ready
);

  localparam int AW = $clog2(DEPTH);

  data_t      mem [DEPTH];
  logic       armed;     // Wait count drawn for the current access
  logic [1:0] wait_cnt;
  integer     seed;

  initial begin
    seed = SEED;
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = addr_t'(i * 4) + FILL_BASE; // Byte address plus base
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Access with random wait states

  always @(posedge clk) begin
    logic [1:0] waits;
    if (rst) begin
      bus_ready <= 1'b0;
      armed     <= 1'b0;
      wait_cnt  <= 2'd0;
    end else if (bus_ready) begin
      bus_ready <= 1'b0; // One ready cycle per transfer
      armed     <= 1'b0;
    end else if (bus_sel) begin
      waits = armed ? wait_cnt : 2'($random(seed));
      if (waits == 2'd0) begin
        bus_ready <= 1'b1;
        bus_rdata <= mem[bus_addr[AW+1:2]];
        if (bus_write) mem[bus_addr[AW+1:2]] <= bus_wdata;
      end else begin
        armed    <= 1'b1;
        wait_cnt <= waits - 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/dma_top.sv */
/*
 * DMA controller top level
 * Config slave, request table, transfer engine, remote port
 * and master bus arbiter
 */

`timescale 1ns/1ps
`default_nettype none

module dma_top
  import dma_pkg::*;
#(
  parameter int TABLE_ENTRIES = 4
) (
  input  logic                     clk,
  input  logic                     rst,

  input  logic                     cfg_sel,
  input  addr_t                    cfg_addr,
  input  logic                     cfg_write,
  input  data_t                    cfg_wdata,
  output data_t                    cfg_rdata,
  output logic                     cfg_ready,

  output logic                     bus_sel,
  output addr_t                    bus_addr,
  output logic                     bus_write,
  output data_t                    bus_wdata,
  input  data_t                    bus_rdata,
  input  logic                     bus_ready,
  output logic                     bus_lock,

  input  logic                     rem_req_valid,
  output logic                     rem_req_ready,
  input  logic                     rem_req_write,
  input  addr_t                    rem_req_addr,
  input  data_t                    rem_req_wdata,
  output logic                     rem_res_valid,
  input  logic                     rem_res_ready,
  output data_t                    rem_res_rdata,

  output logic [TABLE_ENTRIES-1:0] irq
);

  localparam int IDX_W = (TABLE_ENTRIES > 1) ? $clog2(TABLE_ENTRIES) : 1;

  // Config slave to table
  logic                     wr_en;
  logic [IDX_W-1:0]         wr_entry;
  reg_sel_e                 wr_reg;
  data_t                    wr_data;
  logic [IDX_W-1:0]         rd_entry;
  reg_sel_e                 rd_reg;
  data_t                    rd_data;

  // Engine, table and counter
  logic [IDX_W-1:0]         sel_entry;
  logic                     done_set;
  addr_t                    src;
  addr_t                    dst;
  len_t                     len;
  logic [TABLE_ENTRIES-1:0] valid;
  logic                     load;
  logic                     step;
  addr_t                    cur_src;
  addr_t                    cur_dst;
  logic                     last;

  // Masters to arbiter
  logic                     eng_sel;
  addr_t                    eng_addr;
  logic                     eng_write;
  data_t                    eng_wdata;
  logic                     eng_lock;
  logic                     eng_ready;
  data_t                    eng_rdata;
  logic                     rem_sel;
  addr_t                    rem_addr;
  logic                     rem_write;
  data_t                    rem_wdata;
  logic                     rem_lock;
  logic                     rem_ready;
  data_t                    rem_rdata;

  dma_config_slave #(.TABLE_ENTRIES(TABLE_ENTRIES)) i_cfg (
    .clk       (clk),
    .rst       (rst),
    .cfg_sel   (cfg_sel),
    .cfg_addr  (cfg_addr),
    .cfg_write (cfg_write),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .cfg_ready (cfg_ready),
    .wr_en     (wr_en),
    .wr_entry  (wr_entry),
    .wr_reg    (wr_reg),
    .wr_data   (wr_data),
    .rd_entry  (rd_entry),
    .rd_reg    (rd_reg),
    .rd_data   (rd_data)
  );

  dma_request_table #(.TABLE_ENTRIES(TABLE_ENTRIES)) i_table (
    .clk       (clk),
    .rst       (rst),
    .wr_en     (wr_en),
    .wr_entry  (wr_entry),
    .wr_reg    (wr_reg),
    .wr_data   (wr_data),
    .rd_entry  (rd_entry),
    .rd_reg    (rd_reg),
    .rd_data   (rd_data),
    .sel_entry (sel_entry),
    .done_set  (done_set),
    .src       (src),
    .dst       (dst),
    .len       (len),
    .valid     (valid),
    .irq       (irq)
  );

  dma_transfer_fsm #(.TABLE_ENTRIES(TABLE_ENTRIES)) i_fsm (
    .clk       (clk),
    .rst       (rst),
    .valid     (valid),
    .len       (len),
    .sel_entry (sel_entry),
    .done_set  (done_set),
    .load      (load),
    .step      (step),
    .cur_src   (cur_src),
    .cur_dst   (cur_dst),
    .last      (last),
    .eng_sel   (eng_sel),
    .eng_addr  (eng_addr),
    .eng_write (eng_write),
    .eng_wdata (eng_wdata),
    .eng_lock  (eng_lock),
    .eng_ready (eng_ready),
    .eng_rdata (eng_rdata)
  );

  dma_word_counter i_counter (
    .clk     (clk),
    .rst     (rst),
    .load    (load),
    .step    (step),
    .src     (src),
    .dst     (dst),
    .len     (len),
    .cur_src (cur_src),
    .cur_dst (cur_dst),
    .last    (last)
  );

  dma_remote_port i_remote (
    .clk           (clk),
    .rst           (rst),
    .rem_req_valid (rem_req_valid),
    .rem_req_ready (rem_req_ready),
    .rem_req_write (rem_req_write),
    .rem_req_addr  (rem_req_addr),
    .rem_req_wdata (rem_req_wdata),
    .rem_res_valid (rem_res_valid),
    .rem_res_ready (rem_res_ready),
    .rem_res_rdata (rem_res_rdata),
    .rem_sel       (rem_sel),
    .rem_write     (rem_write),
    .rem_addr      (rem_addr),
    .rem_wdata     (rem_wdata),
    .rem_lock      (rem_lock),
    .rem_ready     (rem_ready),
    .rem_rdata     (rem_rdata)
  );

  dma_bus_arbiter i_arbiter (
    .clk       (clk),
    .rst       (rst),
    .rem_sel   (rem_sel),
    .rem_addr  (rem_addr),
    .rem_write (rem_write),
    .rem_wdata (rem_wdata),
    .rem_lock  (rem_lock),
    .rem_ready (rem_ready),
    .rem_rdata (rem_rdata),
    .eng_sel   (eng_sel),
    .eng_addr  (eng_addr),
    .eng_write (eng_write),
    .eng_wdata (eng_wdata),
    .eng_lock  (eng_lock),
    .eng_ready (eng_ready),
    .eng_rdata (eng_rdata),
    .bus_sel   (bus_sel),
    .bus_addr  (bus_addr),
    .bus_write (bus_write),
    .bus_wdata (bus_wdata),
    .bus_lock  (bus_lock),
    .bus_ready (bus_ready),
    .bus_rdata (bus_rdata)
  );

endmodule

`default_nettype wire

/* hdl/dma_bus_arbiter.sv */
/*
 * DMA master bus arbiter
 * Registered owner held while its lock is high, remote port
 * preferred otherwise; muxes the owner onto the master bus
 */

`timescale 1ns/1ps
`default_nettype none

module dma_bus_arbiter
  import dma_pkg::*;
(
  input  logic  clk,
  input  logic  rst,

  input  logic  rem_sel,
  input  addr_t rem_addr,
  input  logic  rem_write,
  input  data_t rem_wdata,
  input  logic  rem_lock,
  output logic  rem_ready,
  output data_t rem_rdata,

  input  logic  eng_sel,
  input  addr_t eng_addr,
  input  logic  eng_write,
  input  data_t eng_wdata,
  input  logic  eng_lock,
  output logic  eng_ready,
  output data_t eng_rdata,

  output logic  bus_sel,
  output addr_t bus_addr,
  output logic  bus_write,
  output data_t bus_wdata,
  output logic  bus_lock,
  input  logic  bus_ready,
  input  data_t bus_rdata
);

  bus_owner_e owner;
  bus_owner_e owner_nxt;
  logic       owner_held;

  assign owner_held = (owner == OWN_REMOTE) ? rem_lock : eng_lock;

  always_comb begin
    if (owner_held)    owner_nxt = owner;
    else if (rem_lock) owner_nxt = OWN_REMOTE;
    else if (eng_lock) owner_nxt = OWN_ENGINE;
    else               owner_nxt = OWN_REMOTE; // Idle default
  end

  always_ff @(posedge clk) begin
    if (rst) owner <= OWN_REMOTE;
    else     owner <= owner_nxt;
  end

  //////////////////////////////////////////////////////////////////////
  // Bus multiplexer

  always_comb begin
    if (owner == OWN_ENGINE) begin
      bus_sel   = eng_sel;
      bus_addr  = eng_addr;
      bus_write = eng_write;
      bus_wdata = eng_wdata;
      bus_lock  = eng_lock;
    end else begin
      bus_sel   = rem_sel;
      bus_addr  = rem_addr;
      bus_write = rem_write;
      bus_wdata = rem_wdata;
      bus_lock  = rem_lock;
    end
  end

  // The other master just sees a long wait
  assign rem_ready = bus_ready & (owner == OWN_REMOTE);
  assign eng_ready = bus_ready & (owner == OWN_ENGINE);
  assign rem_rdata = bus_rdata;
  assign eng_rdata = bus_rdata;

endmodule

`default_nettype wire

/* hdl/dma_remote_port.sv */
/*
 * DMA remote access port
 * Turns one remote read or write request at a time into a locked
 * master bus transfer and returns a response for each
 */

`timescale 1ns/1ps
`default_nettype none

module dma_remote_port
  import dma_pkg::*;
(
  input  logic  clk,
  input  logic  rst,

  input  logic  rem_req_valid,
  output logic  rem_req_ready,
  input  logic  rem_req_write,
  input  addr_t rem_req_addr,
  input  data_t rem_req_wdata,

  output logic  rem_res_valid,
  input  logic  rem_res_ready,
  output data_t rem_res_rdata,

  output logic  rem_sel,
  output logic  rem_write,
  output addr_t rem_addr,
  output data_t rem_wdata,
  output logic  rem_lock,
  input  logic  rem_ready,
  input  data_t rem_rdata
);

  logic busy;

  assign rem_req_ready = ~busy & ~rem_res_valid; // One request in flight

  always_ff @(posedge clk) begin
    if (rst) begin
      busy          <= 1'b0;
      rem_res_valid <= 1'b0;
    end else begin
      if (rem_req_valid && rem_req_ready) busy <= 1'b1;
      if (busy && rem_ready) begin
        busy          <= 1'b0;
        rem_res_valid <= 1'b1;
      end
      if (rem_res_valid && rem_res_ready) rem_res_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rem_req_valid && rem_req_ready) begin
      rem_write <= rem_req_write;
      rem_addr  <= rem_req_addr;
      rem_wdata <= rem_req_wdata;
    end
    if (busy && rem_ready) rem_res_rdata <= rem_rdata; // Held under back-pressure
  end

  assign rem_sel  = busy;
  assign rem_lock = busy;

endmodule

`default_nettype wire

/* hdl/dma_word_counter.sv */
/*
 * DMA word counter
 * Running source and destination addresses and remaining words
 */

`timescale 1ns/1ps
`default_nettype none

module dma_word_counter
  import dma_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  load,
  input  logic  step,
  input  addr_t src,
  input  addr_t dst,
  input  len_t  len,
  output addr_t cur_src,
  output addr_t cur_dst,
  output logic  last
);

  len_t remain;

  always_ff @(posedge clk) begin
    if (rst) begin
      remain <= '0;
    end else if (load) begin
      remain <= len;
    end else if (step) begin
      remain <= remain - len_t'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      cur_src <= src;
      cur_dst <= dst;
    end else if (step) begin
      cur_src <= cur_src + addr_t'(4); // Word addresses
      cur_dst <= cur_dst + addr_t'(4);
    end
  end

  assign last = (remain == len_t'(1)); // Final word of the entry

endmodule

`default_nettype wire

/* hdl/dma_transfer_fsm.sv */
/*
 * DMA transfer engine
 * Picks the lowest valid entry and copies it word by word,
 * each word a locked read then write on the master bus
 */

`timescale 1ns/1ps
`default_nettype none

module dma_transfer_fsm
  import dma_pkg::*;
#(
  parameter int TABLE_ENTRIES = 4,
  localparam int IDX_W = (TABLE_ENTRIES > 1) ? $clog2(TABLE_ENTRIES) : 1
) (
  input  logic                     clk,
  input  logic                     rst,

  input  logic [TABLE_ENTRIES-1:0] valid,
  input  len_t                     len,
  output logic [IDX_W-1:0]         sel_entry,
  output logic                     done_set,

  output logic                     load,
  output logic                     step,
  input  addr_t                    cur_src,
  input  addr_t                    cur_dst,
  input  logic                     last,

  output logic                     eng_sel,
  output addr_t                    eng_addr,
  output logic                     eng_write,
  output data_t                    eng_wdata,
  output logic                     eng_lock,
  input  logic                     eng_ready,
  input  data_t                    eng_rdata
);

  xfer_state_e      state;
  logic [IDX_W-1:0] pick;
  logic             lock_q;
  data_t            data_q;

  // Lowest numbered valid entry
  always_comb begin
    pick = '0;
    for (int i = TABLE_ENTRIES - 1; i >= 0; i--) begin
      if (valid[i]) pick = IDX_W'(i);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // State sequence

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= ST_IDLE;
      lock_q <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (|valid) state <= ST_LOAD;
        end
        ST_LOAD: state <= (len == '0) ? ST_DONE : ST_READ;
        ST_READ: begin
          if (!lock_q) begin
            lock_q <= 1'b1; // Ask for the bus first
          end else if (eng_ready) begin
            state <= ST_WRITE;
          end
        end
        ST_WRITE: begin
          if (eng_ready) begin
            lock_q <= 1'b0; // Let the remote port in between words
            state  <= last ? ST_DONE : ST_READ;
          end
        end
        default: state <= ST_IDLE; // ST_DONE
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_IDLE) sel_entry <= pick;
    if (state == ST_READ && lock_q && eng_ready) data_q <= eng_rdata;
  end

  assign load     = (state == ST_LOAD);
  assign step     = (state == ST_WRITE) & eng_ready;
  assign done_set = (state == ST_DONE);

  assign eng_lock  = lock_q;
  assign eng_sel   = lock_q & ((state == ST_READ) | (state == ST_WRITE));
  assign eng_write = (state == ST_WRITE);
  assign eng_addr  = (state == ST_WRITE) ? cur_dst : cur_src;
  assign eng_wdata = data_q;

endmodule

`default_nettype wire

/* hdl/dma_request_table.sv */
/*
 * DMA request table
 * Holds source, destination and length of each descriptor
 * with its valid and done bits; done drives the interrupts
 */

`timescale 1ns/1ps
`default_nettype none

module dma_request_table
  import dma_pkg::*;
#(
  parameter int TABLE_ENTRIES = 4,
  localparam int IDX_W = (TABLE_ENTRIES > 1) ? $clog2(TABLE_ENTRIES) : 1
) (
  input  logic                     clk,
  input  logic                     rst,

  // Configuration side
  input  logic                     wr_en,
  input  logic [IDX_W-1:0]         wr_entry,
  input  reg_sel_e                 wr_reg,
  input  data_t                    wr_data,
  input  logic [IDX_W-1:0]         rd_entry,
  input  reg_sel_e                 rd_reg,
  output data_t                    rd_data,

  // Engine side
  input  logic [IDX_W-1:0]         sel_entry,
  input  logic                     done_set,
  output addr_t                    src,
  output addr_t                    dst,
  output len_t                     len,
  output logic [TABLE_ENTRIES-1:0] valid,
  output logic [TABLE_ENTRIES-1:0] irq
);

  addr_t                    src_q [TABLE_ENTRIES];
  addr_t                    dst_q [TABLE_ENTRIES];
  len_t                     len_q [TABLE_ENTRIES];
  logic [TABLE_ENTRIES-1:0] valid_q;
  logic [TABLE_ENTRIES-1:0] done_q;

  //////////////////////////////////////////////////////////////////////
  // Descriptor fields

  always_ff @(posedge clk) begin
    if (wr_en) begin
      case (wr_reg)
        REG_SRC: src_q[wr_entry] <= wr_data;
        REG_DST: dst_q[wr_entry] <= wr_data;
        REG_LEN: len_q[wr_entry] <= wr_data[15:0];
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Valid and done bits

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      done_q  <= '0;
    end else begin
      if (done_set) begin
        valid_q[sel_entry] <= 1'b0;
        done_q[sel_entry]  <= 1'b1;
      end
      // A restart in the same cycle wins
      if (wr_en && wr_reg == REG_CTRL && wr_data[0]) begin
        valid_q[wr_entry] <= 1'b1;
        done_q[wr_entry]  <= 1'b0;
      end
    end
  end

  always_comb begin
    case (rd_reg)
      REG_SRC: rd_data = src_q[rd_entry];
      REG_DST: rd_data = dst_q[rd_entry];
      REG_LEN: rd_data = data_t'(len_q[rd_entry]);
      default: rd_data = {30'd0, done_q[rd_entry], valid_q[rd_entry]};
    endcase
  end

  assign src   = src_q[sel_entry];
  assign dst   = dst_q[sel_entry];
  assign len   = len_q[sel_entry];
  assign valid = valid_q;
  assign irq   = done_q; // One line per entry, high while done

endmodule

`default_nettype wire

/* hdl/dma_config_slave.sv */
/*
 * DMA configuration slave
 * Splits config bus accesses into descriptor table writes and reads,
 * answers every access with ready one cycle after select
 */

`timescale 1ns/1ps
`default_nettype none

module dma_config_slave
  import dma_pkg::*;
#(
  parameter int TABLE_ENTRIES = 4,
  localparam int IDX_W = (TABLE_ENTRIES > 1) ? $clog2(TABLE_ENTRIES) : 1
) (
  input  logic             clk,
  input  logic             rst,

  input  logic             cfg_sel,
  input  addr_t            cfg_addr,
  input  logic             cfg_write,
  input  data_t            cfg_wdata,
  output data_t            cfg_rdata,
  output logic             cfg_ready,

  output logic             wr_en,
  output logic [IDX_W-1:0] wr_entry,
  output reg_sel_e         wr_reg,
  output data_t            wr_data,
  output logic [IDX_W-1:0] rd_entry,
  output reg_sel_e         rd_reg,
  input  data_t            rd_data
);

  logic [IDX_W-1:0] entry;
  reg_sel_e         regsel;

  // Address decode
  assign entry  = cfg_addr[ENTRY_SHIFT +: IDX_W];
  assign regsel = reg_sel_e'(cfg_addr[3:2]);

  assign wr_entry = entry;
  assign wr_reg   = regsel;
  assign wr_data  = cfg_wdata;
  assign rd_entry = entry;
  assign rd_reg   = regsel;

  // Commit the write once, in the ready cycle
  assign wr_en = cfg_sel & cfg_write & cfg_ready;

  //////////////////////////////////////////////////////////////////////
  // Single wait state

  always_ff @(posedge clk) begin
    if (rst) begin
      cfg_ready <= 1'b0;
    end else begin
      cfg_ready <= cfg_sel & ~cfg_ready; // Low again after each access
    end
  end

  always_ff @(posedge clk) begin
    if (cfg_sel && !cfg_ready) begin
      cfg_rdata <= rd_data; // Valid in the ready cycle
    end
  end

endmodule

`default_nettype wire

/* hdl/dma_pkg.sv */
/*
 * DMA controller shared definitions
 * Bus word types, descriptor register select, engine states,
 * bus owner encoding and the configuration address layout
 */

`default_nettype none

package dma_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [15:0] len_t; // Transfer length in words

  // Register within a descriptor, config address bits 3..2
  typedef enum logic [1:0] {
    REG_SRC  = 2'd0,
    REG_DST  = 2'd1,
    REG_LEN  = 2'd2,
    REG_CTRL = 2'd3
  } reg_sel_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOAD,
    ST_READ,
    ST_WRITE,
    ST_DONE
  } xfer_state_e;

  typedef enum logic {
    OWN_REMOTE = 1'b0,
    OWN_ENGINE = 1'b1
  } bus_owner_e;

  // Entry index starts here in the config address
  localparam int ENTRY_SHIFT = 4;

endpackage

`default_nettype wire
